// ==== hdl/cpu_isa_pkg.sv ====
// instruction set facts for the reduced mips subset
// word, register index and field types, opcode and funct codes
`default_nettype none

package cpu_isa_pkg;

   // basic widths
   typedef logic [31:0] word_t;     // data word or byte address
   typedef logic [4:0]  regbits_t;  // register index
   typedef logic [5:0]  opcode_t;   // instr[31:26]
   typedef logic [5:0]  funct_t;    // instr[5:0]
   typedef logic [15:0] imm_t;      // instr[15:0]

   // r-type field layout
   typedef struct packed {
      opcode_t  opcode;
      regbits_t rs;
      regbits_t rt;
      regbits_t rd;
      logic [4:0] shamt;            // not decoded in this subset
      funct_t   funct;
   } rtype_t;

   // i-type field layout
   typedef struct packed {
      opcode_t  opcode;
      regbits_t rs;
      regbits_t rt;
      imm_t     imm;
   } itype_t;

   // opcodes
   localparam opcode_t OP_RTYPE = 6'h00;
   localparam opcode_t OP_BEQ   = 6'h04;
   localparam opcode_t OP_ADDIU = 6'h09;
   localparam opcode_t OP_ORI   = 6'h0d;
   localparam opcode_t OP_LW    = 6'h23;
   localparam opcode_t OP_SW    = 6'h2b;
   localparam opcode_t OP_HALT  = 6'h3f;  // all ones

   // funct codes, r-type only
   localparam funct_t FN_ADDU = 6'h21;
   localparam funct_t FN_SUBU = 6'h23;
   localparam funct_t FN_AND  = 6'h24;
   localparam funct_t FN_OR   = 6'h25;
   localparam funct_t FN_SLT  = 6'h2a;

   localparam int       NUM_REGS = 32;
   localparam regbits_t REG_ZERO = 5'd0;  // hardwired zero

endpackage

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
// pipeline stage records: control bundle, stage registers
// alu op codes and forward select codes
`default_nettype none

package pipe_pkg;
   import cpu_isa_pkg::*;

   typedef logic [2:0] aluop_t;
   localparam aluop_t ALU_ADD = 3'd0;
   localparam aluop_t ALU_SUB = 3'd1;
   localparam aluop_t ALU_AND = 3'd2;
   localparam aluop_t ALU_OR  = 3'd3;
   localparam aluop_t ALU_SLT = 3'd4;

   // execute operand source
   typedef logic [1:0] fwd_sel_t;
   localparam fwd_sel_t FWD_REG   = 2'd0;  // value read in decode
   localparam fwd_sel_t FWD_EXMEM = 2'd1;  // alu result one stage ahead
   localparam fwd_sel_t FWD_MEMWB = 2'd2;  // writeback value

   typedef struct packed {
      logic   reg_write;
      logic   mem_read;
      logic   mem_write;
      logic   alu_src_imm;  // operand b from immediate
      logic   zero_ext;     // ori style immediate
      logic   dst_rt;       // i-type destination
      logic   branch;
      logic   halt;
      aluop_t aluop;
   } ctrl_t;

   typedef struct packed {
      logic  valid;
      word_t instr;
      word_t npc;
   } ifid_t;

   typedef struct packed {
      logic     valid;
      ctrl_t    ctrl;
      word_t    npc;
      word_t    rdat1;
      word_t    rdat2;
      word_t    imm_ext;
      regbits_t rs;
      regbits_t rt;
      regbits_t dst;
   } idex_t;

   typedef struct packed {
      logic     valid;
      ctrl_t    ctrl;
      word_t    alu_res;    // also the data address
      word_t    store_dat;
      regbits_t dst;
   } exmem_t;

   typedef struct packed {
      logic     valid;
      logic     reg_write;
      logic     mem_to_reg;
      logic     halt;
      word_t    alu_res;
      word_t    load_dat;
      regbits_t dst;
   } memwb_t;

endpackage

`default_nettype wire

// ==== hdl/register_file.sv ====
// 32 entry register file, r0 reads zero
// two combinational read ports with write-through
`default_nettype none

module register_file
   import cpu_isa_pkg::*;
(
   input  logic     CLK,
   input  logic     nRST,
   input  logic     wen_i,
   input  regbits_t wsel_i,
   input  word_t    wdat_i,
   input  regbits_t rsel1_i,
   input  regbits_t rsel2_i,
   output word_t    rdat1_o,
   output word_t    rdat2_o
);

   word_t regs [NUM_REGS];  // entry 0 never written

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wen_i && wsel_i != REG_ZERO) begin
         regs[wsel_i] <= wdat_i;
      end
   end

   // same-cycle write shows up on the read side
   always_comb begin
      if (rsel1_i == REG_ZERO)                rdat1_o = '0;
      else if (wen_i && wsel_i == rsel1_i)    rdat1_o = wdat_i;  // bypass
      else                                    rdat1_o = regs[rsel1_i];
      if (rsel2_i == REG_ZERO)                rdat2_o = '0;
      else if (wen_i && wsel_i == rsel2_i)    rdat2_o = wdat_i;  // bypass
      else                                    rdat2_o = regs[rsel2_i];
   end

endmodule

`default_nettype wire

// ==== hdl/control_unit.sv ====
// main decoder, opcode and funct to control bundle
`default_nettype none

module control_unit
   import cpu_isa_pkg::*;
   import pipe_pkg::*;
(
   input  opcode_t opcode_i,
   input  funct_t  funct_i,
   output ctrl_t   ctrl_o
);

   always_comb begin
      ctrl_o = '0;  // default is a no-op
      ctrl_o.aluop = ALU_ADD;
      case (opcode_i)
         OP_RTYPE: begin
            ctrl_o.reg_write = 1'b1;
            case (funct_i)
               FN_ADDU: ctrl_o.aluop = ALU_ADD;
               FN_SUBU: ctrl_o.aluop = ALU_SUB;
               FN_AND:  ctrl_o.aluop = ALU_AND;
               FN_OR:   ctrl_o.aluop = ALU_OR;
               FN_SLT:  ctrl_o.aluop = ALU_SLT;
               default: ctrl_o.reg_write = 1'b0;  // unknown funct, no write
            endcase
         end
         OP_ADDIU: begin
            ctrl_o.reg_write   = 1'b1;
            ctrl_o.alu_src_imm = 1'b1;
            ctrl_o.dst_rt      = 1'b1;
         end
         OP_ORI: begin
            ctrl_o.reg_write   = 1'b1;
            ctrl_o.alu_src_imm = 1'b1;
            ctrl_o.zero_ext    = 1'b1;
            ctrl_o.dst_rt      = 1'b1;
            ctrl_o.aluop       = ALU_OR;
         end
         OP_LW: begin
            ctrl_o.reg_write   = 1'b1;
            ctrl_o.mem_read    = 1'b1;
            ctrl_o.alu_src_imm = 1'b1;  // base + offset
            ctrl_o.dst_rt      = 1'b1;
         end
         OP_SW: begin
            ctrl_o.mem_write   = 1'b1;
            ctrl_o.alu_src_imm = 1'b1;
         end
         OP_BEQ: begin
            ctrl_o.branch = 1'b1;
            ctrl_o.aluop  = ALU_SUB;     // zero flag on equal
         end
         OP_HALT: ctrl_o.halt = 1'b1;
         default: ;                      // unknown opcode stays a no-op
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
// integer alu: add, sub, and, or, signed slt, zero flag
`default_nettype none

module alu
   import cpu_isa_pkg::*;
   import pipe_pkg::*;
(
   input  aluop_t op_i,
   input  word_t  a_i,
   input  word_t  b_i,
   output word_t  result_o,
   output logic   zero_o
);

   always_comb begin
      case (op_i)
         ALU_ADD: result_o = a_i + b_i;
         ALU_SUB: result_o = a_i - b_i;
         ALU_AND: result_o = a_i & b_i;
         ALU_OR:  result_o = a_i | b_i;
         ALU_SLT: result_o = {31'b0, $signed(a_i) < $signed(b_i)};
         default: result_o = '0;
      endcase
   end

   assign zero_o = (result_o == '0);  // beq compare

endmodule

`default_nettype wire

// ==== hdl/hazard_unit.sv ====
// forwarding selects for both execute operands
// and the load-use stall request
`default_nettype none

module hazard_unit
   import cpu_isa_pkg::*;
   import pipe_pkg::*;
(
   input  idex_t    idex_i,
   input  exmem_t   exmem_i,
   input  memwb_t   memwb_i,
   input  regbits_t dec_rs_i,
   input  regbits_t dec_rt_i,
   output fwd_sel_t fwd_a_o,
   output fwd_sel_t fwd_b_o,
   output logic     load_stall_o
);

   logic exmem_fwd_ok;  // ex/mem result usable for forwarding
   logic memwb_fwd_ok;

   // youngest older writer of one source register
   function automatic fwd_sel_t pick_src(input regbits_t src, input logic ex_ok,
                                         input logic wb_ok);
      fwd_sel_t sel;
      sel = FWD_REG;
      if (src == REG_ZERO) begin
         sel = FWD_REG;                          // r0 is never forwarded
      end else if (ex_ok && exmem_i.dst == src) begin
         sel = FWD_EXMEM;
      end else if (wb_ok && memwb_i.dst == src) begin
         sel = FWD_MEMWB;
      end
      return sel;
   endfunction

   // a load in ex/mem has no data yet
   assign exmem_fwd_ok = exmem_i.valid && exmem_i.ctrl.reg_write && !exmem_i.ctrl.mem_read;
   assign memwb_fwd_ok = memwb_i.valid && memwb_i.reg_write;

   always_comb fwd_a_o = pick_src(idex_i.rs, exmem_fwd_ok, memwb_fwd_ok);
   always_comb fwd_b_o = pick_src(idex_i.rt, exmem_fwd_ok, memwb_fwd_ok);

   ////////////////////////////////////////////////////////////////////
   // load-use with a load in execute and its target read in decode
   always_comb begin
      load_stall_o = 1'b0;
      if (idex_i.valid && idex_i.ctrl.mem_read && idex_i.dst != REG_ZERO) begin
         load_stall_o = (idex_i.dst == dec_rs_i) || (idex_i.dst == dec_rt_i);
      end
   end

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
// program counter, next pc choice, instruction request
`default_nettype none

module fetch_stage
   import cpu_isa_pkg::*;
#(
   parameter word_t PC_INIT = '0
) (
   input  logic  CLK,
   input  logic  nRST,
   input  logic  stall_i,         // global freeze
   input  logic  hold_i,          // load-use bubble
   input  logic  branch_taken_i,
   input  word_t branch_target_i,
   input  logic  halted_i,
   output word_t imemaddr_o,
   output logic  imemren_o,
   output word_t npc_o
);

   word_t pc_q;

   assign npc_o      = pc_q + 32'd4;
   assign imemaddr_o = pc_q;       // stable while stalled
   assign imemren_o  = !halted_i;  // no fetch once halted

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         pc_q <= PC_INIT;
      end else if (!stall_i && !halted_i) begin
         if (branch_taken_i)  pc_q <= branch_target_i;  // redirect from ex
         else if (!hold_i)    pc_q <= npc_o;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/datapath.sv ====
// five stage pipeline top with stage registers, forwarding muxes,
// stall and flush control, data memory port, halt flag
`default_nettype none

module datapath
   import cpu_isa_pkg::*;
   import pipe_pkg::*;
#(
   parameter word_t PC_INIT = '0
) (
   input  logic  CLK,
   input  logic  nRST,
   // instruction memory
   output word_t imemaddr_o,
   output logic  imemren_o,
   input  word_t imemload_i,
   input  logic  ihit_i,
   // data memory
   output word_t dmemaddr_o,
   output word_t dmemstore_o,
   output logic  dmemren_o,
   output logic  dmemwen_o,
   input  word_t dmemload_i,
   input  logic  dhit_i,
   output logic  halt_o
);

   ifid_t  ifid_q, ifid_d;
   idex_t  idex_q, idex_d;
   exmem_t exmem_q, exmem_d;
   memwb_t memwb_q, memwb_d;

   rtype_t   dec_r;
   itype_t   dec_i;
   ctrl_t    dec_ctrl;
   word_t    rdat1, rdat2, imm_ext, wb_dat, npc;
   word_t    opa, opb, alu_b, alu_res, branch_target;
   word_t    dload_q;                 // load data kept across a freeze
   fwd_sel_t fwd_a, fwd_b;
   logic     alu_zero, branch_taken, load_stall, load_use;
   logic     stall, dwait, dacc_done_q, halt_q, halt_pend;

   function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val);
      word_t val;
      case (sel)
         FWD_EXMEM: val = exmem_q.alu_res;
         FWD_MEMWB: val = wb_dat;
         default:   val = reg_val;
      endcase
      return val;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // fetch
   fetch_stage #(.PC_INIT(PC_INIT)) fetch0 (
      .CLK, .nRST,
      .stall_i(stall), .hold_i(load_use),
      .branch_taken_i(branch_taken), .branch_target_i(branch_target),
      .halted_i(halt_q),
      .imemaddr_o, .imemren_o, .npc_o(npc)
   );

   assign ifid_d.valid = imemren_o && !branch_taken;  // fetched slot dies on branch
   assign ifid_d.instr = imemload_i;
   assign ifid_d.npc   = npc;

   //////////////////////////////////////////////////////////////////////
   // decode
   assign dec_r = rtype_t'(ifid_q.instr);
   assign dec_i = itype_t'(ifid_q.instr);

   control_unit ctrl0 (.opcode_i(dec_r.opcode), .funct_i(dec_r.funct), .ctrl_o(dec_ctrl));

   register_file rf0 (
      .CLK, .nRST,
      .wen_i(memwb_q.valid && memwb_q.reg_write), .wsel_i(memwb_q.dst), .wdat_i(wb_dat),
      .rsel1_i(dec_r.rs), .rsel2_i(dec_r.rt), .rdat1_o(rdat1), .rdat2_o(rdat2)
   );

   hazard_unit haz0 (
      .idex_i(idex_q), .exmem_i(exmem_q), .memwb_i(memwb_q),
      .dec_rs_i(dec_r.rs), .dec_rt_i(dec_r.rt),
      .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .load_stall_o(load_stall)
   );

   assign load_use = load_stall && ifid_q.valid;
   assign imm_ext  = dec_ctrl.zero_ext ? {16'b0, dec_i.imm} : {{16{dec_i.imm[15]}}, dec_i.imm};

   // anything behind a halt is squashed before execute
   assign halt_pend = halt_q || (idex_q.valid && idex_q.ctrl.halt)
                   || (exmem_q.valid && exmem_q.ctrl.halt) || (memwb_q.valid && memwb_q.halt);

   always_comb begin
      idex_d.valid   = ifid_q.valid && !branch_taken && !load_use && !halt_pend;
      idex_d.ctrl    = idex_d.valid ? dec_ctrl : '0;  // bubble
      idex_d.npc     = ifid_q.npc;
      idex_d.rdat1   = rdat1;
      idex_d.rdat2   = rdat2;
      idex_d.imm_ext = imm_ext;
      idex_d.rs      = dec_r.rs;
      idex_d.rt      = dec_r.rt;
      idex_d.dst     = dec_ctrl.dst_rt ? dec_r.rt : dec_r.rd;
   end

   //////////////////////////////////////////////////////////////////////
   // execute
   always_comb opa = fwd_mux(fwd_a, idex_q.rdat1);
   always_comb opb = fwd_mux(fwd_b, idex_q.rdat2);     // also store data
   assign alu_b = idex_q.ctrl.alu_src_imm ? idex_q.imm_ext : opb;

   alu alu0 (.op_i(idex_q.ctrl.aluop), .a_i(opa), .b_i(alu_b),
             .result_o(alu_res), .zero_o(alu_zero));

   assign branch_taken  = idex_q.valid && idex_q.ctrl.branch && alu_zero;
   assign branch_target = idex_q.npc + {idex_q.imm_ext[29:0], 2'b00};

   assign exmem_d = '{valid: idex_q.valid, ctrl: idex_q.ctrl, alu_res: alu_res,
                      store_dat: opb, dst: idex_q.dst};

   //////////////////////////////////////////////////////////////////////
   // memory
   // request drops once answered even while the pipe is still frozen
   assign dmemaddr_o  = exmem_q.alu_res;
   assign dmemstore_o = exmem_q.store_dat;
   assign dmemren_o   = exmem_q.valid && exmem_q.ctrl.mem_read && !dacc_done_q;
   assign dmemwen_o   = exmem_q.valid && exmem_q.ctrl.mem_write && !dacc_done_q;
   assign dwait       = (dmemren_o || dmemwen_o) && !dhit_i;

   assign stall = (imemren_o && !ihit_i) || dwait;    // global freeze

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST)                                  dacc_done_q <= 1'b0;
      else if (!stall)                            dacc_done_q <= 1'b0;
      else if ((dmemren_o || dmemwen_o) && dhit_i) dacc_done_q <= 1'b1;  // hit while frozen
   end

   always_ff @(posedge CLK) begin
      if (dmemren_o && dhit_i) dload_q <= dmemload_i;
   end

   always_comb begin
      memwb_d.valid      = exmem_q.valid;
      memwb_d.reg_write  = exmem_q.ctrl.reg_write;
      memwb_d.mem_to_reg = exmem_q.ctrl.mem_read;
      memwb_d.halt       = exmem_q.ctrl.halt;
      memwb_d.alu_res    = exmem_q.alu_res;
      memwb_d.load_dat   = dacc_done_q ? dload_q : dmemload_i;
      memwb_d.dst        = exmem_q.dst;
   end

   //////////////////////////////////////////////////////////////////////
   // writeback and stage registers
   assign wb_dat = memwb_q.mem_to_reg ? memwb_q.load_dat : memwb_q.alu_res;

   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST) begin
         ifid_q  <= '0;
         idex_q  <= '0;
         exmem_q <= '0;
         memwb_q <= '0;
      end else if (!stall) begin
         if (!load_use) ifid_q <= ifid_d;  // decode holds on load-use
         idex_q  <= idex_d;
         exmem_q <= exmem_d;
         memwb_q <= memwb_d;
      end
   end

   // sticky until reset
   always_ff @(posedge CLK or negedge nRST) begin
      if (!nRST)                              halt_q <= 1'b0;
      else if (memwb_q.valid && memwb_q.halt) halt_q <= 1'b1;
   end

   assign halt_o = halt_q;

endmodule

`default_nettype wire

// ==== test/tb_memory.sv ====
// memory model with random wait states
// one port: read or write request, answered by a registered hit
`default_nettype none

module tb_memory
   import cpu_isa_pkg::*;
#(
   parameter int HIT_PCT = 60  // chance of a hit per cycle
) (
   input  logic  CLK,
   input  logic  load_i,           // copy image_i into the array
   input  word_t image_i [256],
   input  logic  wen_i,
   input  word_t addr_i,
   input  word_t wdat_i,
   output word_t rdat_o,
   output logic  hit_o
);

   word_t mem [256];

   initial begin
      hit_o = 1'b0;
      for (int i = 0; i < 256; i++) mem[i] = '0;
   end

   assign rdat_o = mem[addr_i[9:2]];  // word addressed, wraps at 1 KB

   always @(posedge CLK) begin
      if (load_i) begin
         for (int i = 0; i < 256; i++) mem[i] <= image_i[i];
      end else if (wen_i && hit_o) begin
         mem[addr_i[9:2]] <= wdat_i;   // write lands on the hit edge
      end
      hit_o <= ($urandom % 100) < HIT_PCT;
   end

endmodule

`default_nettype wire

// ==== include/tb_isa_model.svh ====
// instruction encoders and a sequential reference model
// the model turns a program into the list of expected stores
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// initial memory contents, spread over the whole address
function automatic word_t fill_word(input word_t addr);
   return (addr * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
endfunction

function automatic word_t enc_r(input funct_t fn, input regbits_t rd, input regbits_t rs,
                                input regbits_t rt);
   return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t enc_i(input opcode_t op, input regbits_t rt, input regbits_t rs,
                                input int imm);
   return {op, rs, rt, imm[15:0]};  // low 16 bits only
endfunction

function automatic word_t enc_halt();
   return {OP_HALT, 26'd0};
endfunction

// runs prog one instruction at a time, fills exp_addr / exp_data
task automatic run_model();
   word_t regs [32];
   word_t dm [256];
   word_t pc, ins, a, b, imm_s, imm_z, res, addr;
   regbits_t dst;
   logic done, wr;
   int steps;
   for (int i = 0; i < 32; i++) regs[i] = '0;
   for (int i = 0; i < 256; i++) dm[i] = fill_word(word_t'(i) << 2);
   exp_addr.delete();
   exp_data.delete();
   pc = '0;
   done = 1'b0;
   steps = 0;
   while (!done && steps < 1000) begin
      steps++;
      ins   = ((pc >> 2) < prog.size()) ? prog[pc >> 2] : enc_halt();  // off the end stops
      a     = regs[ins[25:21]];
      b     = regs[ins[20:16]];
      imm_s = {{16{ins[15]}}, ins[15:0]};
      imm_z = {16'd0, ins[15:0]};
      addr  = a + imm_s;
      pc    = pc + 32'd4;
      wr    = 1'b1;
      dst   = ins[20:16];  // rt unless r-type
      res   = '0;
      case (ins[31:26])
         OP_RTYPE: begin
            dst = ins[15:11];
            case (ins[5:0])
               FN_ADDU: res = a + b;
               FN_SUBU: res = a - b;
               FN_AND:  res = a & b;
               FN_OR:   res = a | b;
               FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               default: wr = 1'b0;
            endcase
         end
         OP_ADDIU: res = a + imm_s;
         OP_ORI:   res = a | imm_z;
         OP_LW:    res = dm[addr[9:2]];
         OP_SW: begin
            wr = 1'b0;
            exp_addr.push_back(addr);
            exp_data.push_back(b);
            dm[addr[9:2]] = b;
         end
         OP_BEQ: begin
            wr = 1'b0;
            if (a == b) pc = pc + (imm_s << 2);  // relative to pc + 4
         end
         OP_HALT: begin
            wr = 1'b0;
            done = 1'b1;
         end
         default: wr = 1'b0;
      endcase
      if (wr && dst != REG_ZERO) regs[dst] = res;
   end
endtask

`endif

// ==== test/datapath_tb.sv ====
// pipeline testbench with programs, reference stores,
// store checks, handshake and halt checks, timeout
`default_nettype none

module datapath_tb
   import cpu_isa_pkg::*;
();

   logic  CLK, nRST, load;
   word_t imemaddr, imemload, dmemaddr, dmemstore, dmemload;
   logic  imemren, ihit, dmemren, dmemwen, dhit, halt;
   word_t imem_img [256];
   word_t dmem_img [256];
   word_t prog[$];
   word_t exp_addr[$];
   word_t exp_data[$];
   int    store_errs, proto_errs, halt_errs, store_idx, cyc;
   logic  armed, halt_seen, prev_iwait, prev_dwait, timed_out;
   word_t prev_iaddr, prev_daddr;

   `include "tb_isa_model.svh"

   datapath #(.PC_INIT(32'h0)) dut0 (
      .CLK, .nRST,
      .imemaddr_o(imemaddr), .imemren_o(imemren), .imemload_i(imemload), .ihit_i(ihit),
      .dmemaddr_o(dmemaddr), .dmemstore_o(dmemstore), .dmemren_o(dmemren),
      .dmemwen_o(dmemwen), .dmemload_i(dmemload), .dhit_i(dhit), .halt_o(halt)
   );

   tb_memory imem0 (.CLK, .load_i(load), .image_i(imem_img), .wen_i(1'b0),
                    .addr_i(imemaddr), .wdat_i(32'h0), .rdat_o(imemload), .hit_o(ihit));
   tb_memory dmem0 (.CLK, .load_i(load), .image_i(dmem_img), .wen_i(dmemwen),
                    .addr_i(dmemaddr), .wdat_i(dmemstore), .rdat_o(dmemload), .hit_o(dhit));

   initial CLK = 1'b0;
   always #4 CLK = ~CLK;

   //////////////////////////////////////////////////////////////////////
   // all checks use pre-edge values
   always @(posedge CLK) begin
      if (armed && dmemwen && dhit) begin  // accepted store
         assert (store_idx < exp_addr.size() && dmemaddr == exp_addr[store_idx]
                 && dmemstore == exp_data[store_idx])
         else begin
            store_errs++;
            $display("CHECK FAILED t=%0t store %0d at %h data %h is unexpected",
                     $time, store_idx, dmemaddr, dmemstore);
         end
         store_idx++;
      end
      if (armed && !halt) begin
         // a request without a hit stays up with the same address
         if (prev_iwait) assert (imemren && imemaddr == prev_iaddr) else begin
            proto_errs++;
            $display("CHECK FAILED t=%0t fetch request dropped before its hit", $time);
         end
         if (prev_dwait) assert ((dmemren || dmemwen) && dmemaddr == prev_daddr) else begin
            proto_errs++;
            $display("CHECK FAILED t=%0t data request dropped before its hit", $time);
         end
      end
      if (armed && halt) assert (!imemren && !dmemren && !dmemwen) else begin
         halt_errs++;
         $display("CHECK FAILED t=%0t memory request after halt", $time);
      end
      if (armed && halt_seen) assert (halt) else begin
         halt_errs++;
         $display("CHECK FAILED t=%0t halt dropped", $time);
      end
      halt_seen  <= armed && (halt_seen || halt);  // sticky check
      prev_iwait <= armed && imemren && !ihit;
      prev_iaddr <= imemaddr;
      prev_dwait <= armed && (dmemren || dmemwen) && !dhit;
      prev_daddr <= dmemaddr;
   end

   task automatic print_counts();
      $display("errors: store %0d, handshake %0d, halt %0d", store_errs, proto_errs, halt_errs);
   endtask

   // reset and load both memories then run until halt or timeout
   task automatic run_program(input int id);
      int limit;
      run_model();
      for (int i = 0; i < 256; i++) begin
         imem_img[i] = (i < prog.size()) ? prog[i] : fill_word(word_t'(i) << 2);
         dmem_img[i] = fill_word(word_t'(i) << 2);
      end
      limit = 40 * prog.size() * 4;  // wait states included
      @(posedge CLK);
      armed <= 1'b0;
      nRST  <= 1'b0;
      load  <= 1'b1;
      @(posedge CLK);
      load  <= 1'b0;
      @(posedge CLK);
      assert (!halt && !dmemren && !dmemwen) else begin
         proto_errs++;
         $display("CHECK FAILED t=%0t outputs active in reset", $time);
      end
      store_idx = 0;
      nRST  <= 1'b1;
      armed <= 1'b1;
      cyc = 0;
      while (!halt && cyc < limit) begin
         @(posedge CLK);
         cyc++;
      end
      if (!halt) begin
         $display("timeout: program %0d did not halt within %0d cycles", id, limit);
         timed_out = 1'b1;
      end else begin
         assert (store_idx == exp_addr.size()) else begin
            halt_errs++;
            $display("CHECK FAILED t=%0t program %0d made %0d stores, expected %0d",
                     $time, id, store_idx, exp_addr.size());
         end
         repeat (8) @(posedge CLK);  // halt must hold with no more requests
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // programs
   task automatic build_arith_prog();
      prog.delete();
      prog.push_back(enc_i(OP_ORI, 1, 0, int'($urandom)));
      prog.push_back(enc_i(OP_ADDIU, 2, 0, int'($urandom)));  // may be negative
      prog.push_back(enc_r(FN_ADDU, 3, 1, 2));  // r2 from ex/mem and r1 from mem/wb
      prog.push_back(enc_r(FN_SUBU, 4, 3, 1));
      prog.push_back(enc_i(OP_SW, 3, 0, 0));
      prog.push_back(enc_i(OP_SW, 4, 0, 4));
      prog.push_back(enc_r(FN_AND, 5, 4, 3));
      prog.push_back(enc_r(FN_OR, 6, 5, 2));
      prog.push_back(enc_r(FN_SLT, 7, 2, 1));
      prog.push_back(enc_r(FN_SLT, 8, 1, 2));
      prog.push_back(enc_i(OP_SW, 5, 0, 8));
      prog.push_back(enc_i(OP_SW, 6, 0, 12));
      prog.push_back(enc_i(OP_SW, 7, 0, 16));
      prog.push_back(enc_i(OP_SW, 8, 0, 20));
      prog.push_back(enc_i(OP_ORI, 9, 0, 32'h8000));  // zero extended
      prog.push_back(enc_i(OP_SW, 9, 0, 24));
      prog.push_back(enc_i(OP_ADDIU, 10, 0, -1));
      prog.push_back(enc_r(FN_SLT, 11, 10, 0));       // signed compare of -1 and 0
      prog.push_back(enc_i(OP_SW, 11, 0, 28));
      prog.push_back(enc_halt());
   endtask

   task automatic build_load_prog();
      prog.delete();
      prog.push_back(enc_i(OP_ORI, 1, 0, int'($urandom)));
      prog.push_back(enc_i(OP_SW, 1, 0, 16));
      prog.push_back(enc_i(OP_LW, 2, 0, 16));
      prog.push_back(enc_r(FN_ADDU, 3, 2, 2));  // load-use on both sources
      prog.push_back(enc_i(OP_SW, 3, 0, 20));
      prog.push_back(enc_i(OP_LW, 4, 0, 40));   // untouched word
      prog.push_back(enc_i(OP_SW, 4, 0, 24));   // load-use on store data
      prog.push_back(enc_i(OP_LW, 5, 0, 20));
      prog.push_back(enc_r(FN_OR, 6, 5, 1));
      prog.push_back(enc_i(OP_SW, 6, 0, 28));
      prog.push_back(enc_halt());
   endtask

   task automatic build_branch_prog();
      prog.delete();
      prog.push_back(enc_i(OP_ORI, 1, 0, 5));
      prog.push_back(enc_i(OP_ORI, 2, 0, 5));
      prog.push_back(enc_i(OP_BEQ, 2, 1, 2));   // taken and skips two stores
      prog.push_back(enc_i(OP_SW, 1, 0, 0));
      prog.push_back(enc_i(OP_SW, 2, 0, 4));
      prog.push_back(enc_i(OP_SW, 1, 0, 8));
      prog.push_back(enc_i(OP_ORI, 3, 0, 6));
      prog.push_back(enc_i(OP_BEQ, 3, 1, 1));   // not taken
      prog.push_back(enc_i(OP_SW, 3, 0, 12));
      prog.push_back(enc_i(OP_ADDIU, 0, 0, int'($urandom)));  // r0 stays zero
      prog.push_back(enc_i(OP_SW, 0, 0, 16));
      prog.push_back(enc_r(FN_ADDU, 0, 1, 2));
      prog.push_back(enc_i(OP_SW, 0, 0, 20));
      prog.push_back(enc_i(OP_ORI, 4, 0, 3));   // loop count
      prog.push_back(enc_i(OP_ADDIU, 4, 4, -1));
      prog.push_back(enc_i(OP_SW, 4, 0, 32));
      prog.push_back(enc_i(OP_BEQ, 0, 4, 1));   // exit when zero
      prog.push_back(enc_i(OP_BEQ, 0, 0, -4));  // back to loop top
      prog.push_back(enc_i(OP_BEQ, 0, 0, 1));
      prog.push_back(enc_i(OP_SW, 1, 0, 24));   // never stored
      prog.push_back(enc_halt());
   endtask

   initial begin
      void'($urandom(32'h046d_ee51));
      nRST = 1'b1;
      load = 1'b0;
      armed = 1'b0;
      halt_seen = 1'b0;
      prev_iwait = 1'b0;
      prev_dwait = 1'b0;
      prev_iaddr = '0;
      prev_daddr = '0;
      timed_out = 1'b0;
      store_errs = 0;
      proto_errs = 0;
      halt_errs = 0;
      store_idx = 0;
      build_arith_prog();
      run_program(0);
      if (!timed_out) begin
         build_load_prog();
         run_program(1);
      end
      if (!timed_out) begin
         build_branch_prog();
         run_program(2);
      end
      print_counts();
      if (!timed_out && store_errs + proto_errs + halt_errs == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
hdl/cpu_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/register_file.sv
hdl/control_unit.sv
hdl/alu.sv
hdl/hazard_unit.sv
hdl/fetch_stage.sv
hdl/datapath.sv
test/tb_memory.sv
test/datapath_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the pipeline testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
   --top-module datapath_tb -o datapath_sim &&
./obj_dir/datapath_sim | grep "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
